//--- Bender.yml
package:
  name: stopwatch_watch

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/clock_pkg.sv
      - hdl/tick_gen.sv
      - hdl/time_counter.sv
      - hdl/panel_control.sv
      - hdl/stopwatch_core.sv
      - hdl/watch_core.sv
      - hdl/display_format.sv
      - hdl/stopwatch_watch.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tb_stopwatch_watch.sv

//--- dv/tb_stopwatch_watch.sv
`timescale 1ns/1ps
`include "clock_defs.svh"

module tb_stopwatch_watch;

    import clock_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int TICK_DIVIDE  = 5;
    localparam int RESET_CYCLES = 3;

    // phase lengths in clock cycles
    localparam int COUNT_CYCLES  = 1200;
    localparam int HOLD_CYCLES   = 600;
    localparam int FREE_CYCLES   = 500;
    localparam int DOWN_CYCLES   = 800;
    localparam int WRAP_CYCLES   = 2 * 61 + 4;
    localparam int SET_CYCLES    = 900;
    localparam int VIEW_CYCLES   = 800;
    localparam int MARGIN_CYCLES = 200;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 1 + COUNT_CYCLES + HOLD_CYCLES + FREE_CYCLES
                                   + DOWN_CYCLES + WRAP_CYCLES + SET_CYCLES + VIEW_CYCLES;

    // button bits with run_stop as the msb
    localparam logic [3:0] BTN_RUN   = 4'b1000;
    localparam logic [3:0] BTN_CLEAR = 4'b0100;
    localparam logic [3:0] BTN_UP    = 4'b0010;
    localparam logic [3:0] BTN_DOWN  = 4'b0001;
    // switch bits with count_down as the msb
    localparam logic [3:0] SW_DOWN   = 4'b1000;
    localparam logic [3:0] SW_WATCH  = 4'b0100;
    localparam logic [3:0] SW_HM     = 4'b0010;
    localparam logic [3:0] SW_HOUR   = 4'b0001;

    logic        clk;
    logic        reset;
    panel_btn_t  btn_in;
    panel_sw_t   sw_in;
    bcd_digits_t digits;

    int seed;
    int error_count;
    int check_count;
    int hold [4];

    // cycle model state
    panel_btn_t m_btn_prev;
    logic       m_run;
    logic       m_clear;
    logic       m_up;
    logic       m_down;
    logic       sw_tick;
    logic       w_tick;
    int         sw_div;
    int         w_div;
    int         sw_csec, sw_sec, sw_min, sw_hour;
    int         w_csec, w_sec, w_min, w_hour;

    stopwatch_watch #(.TICK_DIVIDE(TICK_DIVIDE)) stopwatch_watch_inst (
        .clk      (clk),
        .reset    (reset),
        .i_btn    (btn_in),
        .i_sw     (sw_in),
        .o_digits (digits)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    // ==================================================
    // cycle model
    // ==================================================
    task automatic reset_model();
        m_btn_prev = '0;
        m_run = 1'b0;
        m_clear = 1'b0;
        m_up = 1'b0;
        m_down = 1'b0;
        sw_tick = 1'b0;
        w_tick = 1'b0;
        sw_div = 0;
        w_div = 0;
        sw_csec = 0;
        sw_sec = 0;
        sw_min = 0;
        sw_hour = 0;
        w_csec = 0;
        w_sec = 0;
        w_min = 0;
        w_hour = 0;
    endtask

    // one modulo stage with the carry taken before the step
    task automatic advance_stage(inout int value, input int modulus, input logic step,
                                 input logic down, input logic clear, output logic carry);
        logic wrap;
        wrap = down ? (value == 0) : (value == modulus - 1);
        carry = step && !clear && wrap;
        if (clear) begin
            value = 0;
        end else if (step) begin
            value = down ? (value + modulus - 1) % modulus : (value + 1) % modulus;
        end
    endtask

    task automatic step_model();
        panel_btn_t rise;
        logic       c0, c1, c2, c3;
        logic       min_pls;
        logic       hour_pls;
        logic       pls_down;
        logic       cd;
        cd = sw_in.count_down;
        // stopwatch steps on its tick only while running
        advance_stage(sw_csec, `CSEC_MOD, sw_tick && m_run, cd, m_clear, c0);
        advance_stage(sw_sec, `SEC_MOD, c0, cd, m_clear, c1);
        advance_stage(sw_min, `MIN_MOD, c1, cd, m_clear, c2);
        advance_stage(sw_hour, `HOUR_MOD, c2, cd, m_clear, c3);
        sw_tick = m_run && (sw_div == TICK_DIVIDE - 1);
        if (m_run) begin
            sw_div = (sw_div + 1) % TICK_DIVIDE;
        end
        // on the watch a step pulse stands in for the carry from below
        min_pls = (m_up || m_down) && !sw_in.set_hour;
        hour_pls = (m_up || m_down) && sw_in.set_hour;
        pls_down = !m_up;
        advance_stage(w_csec, `CSEC_MOD, w_tick, cd, 1'b0, c0);
        advance_stage(w_sec, `SEC_MOD, c0, cd, 1'b0, c1);
        advance_stage(w_min, `MIN_MOD, min_pls || c1, min_pls ? pls_down : cd, 1'b0, c2);
        advance_stage(w_hour, `HOUR_MOD, hour_pls || c2, hour_pls ? pls_down : cd, 1'b0, c3);
        w_tick = (w_div == TICK_DIVIDE - 1);
        w_div = (w_div + 1) % TICK_DIVIDE;
        // input side last since its outputs show up next cycle
        rise = btn_in & ~m_btn_prev;
        m_btn_prev = btn_in;
        m_clear = rise.clear;
        m_up = rise.up;
        m_down = rise.down;
        if (rise.run_stop) begin
            m_run = !m_run;
        end
    endtask

    function automatic logic [15:0] expected_digits();
        int left_val;
        int right_val;
        if (sw_in.show_watch) begin
            left_val = sw_in.show_hm ? w_hour : w_sec;
            right_val = sw_in.show_hm ? w_min : w_csec;
        end else begin
            left_val = sw_in.show_hm ? sw_hour : sw_sec;
            right_val = sw_in.show_hm ? sw_min : sw_csec;
        end
        return {4'(left_val / 10), 4'(left_val % 10), 4'(right_val / 10), 4'(right_val % 10)};
    endfunction

    // ==================================================
    // stimulus and checking
    // ==================================================
    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error [%s] expected %h, actual %h at %0t ns",
                     name, expected, actual, $time);
        end
    endtask

    // sparse presses of 1 to 3 cycles and rare switch flips
    task automatic pick_inputs(input logic [3:0] btn_mask, input logic [3:0] sw_keep,
                               input logic [3:0] sw_val, output logic [3:0] btn_next,
                               output logic [3:0] sw_next);
        logic [31:0] r;
        int          i;
        sw_next = sw_in;
        for (i = 0; i < 4; i++) begin
            r = $random(seed);
            if (hold[i] > 0) begin
                btn_next[i] = 1'b1;
                hold[i]--;
            end else if (btn_mask[i] && r[4:0] == 5'd0) begin
                btn_next[i] = 1'b1;
                hold[i] = int'(r[9:8]) % 3;
            end else begin
                btn_next[i] = 1'b0;
            end
            if (r[20:16] == 5'd0) begin
                sw_next[i] = ~sw_next[i];
            end
        end
        sw_next = (sw_next & ~sw_keep) | (sw_val & sw_keep);
    endtask

    task automatic drive_cycle(input string name, input logic [3:0] btn, input logic [3:0] sw);
        @(posedge clk);
        step_model();
        #10;
        btn_in = btn;
        sw_in = sw;
        #40;
        check_value(name, expected_digits(), digits);
    endtask

    task automatic run_phase(input string name, input int cycles, input logic [3:0] btn_mask,
                             input logic [3:0] sw_keep, input logic [3:0] sw_val);
        logic [3:0] btn_next;
        logic [3:0] sw_next;
        repeat (cycles) begin
            pick_inputs(btn_mask, sw_keep, sw_val, btn_next, sw_next);
            drive_cycle(name, btn_next, sw_next);
        end
    endtask

    initial begin : stimulus
        int combo;
        reset = 1'b1;
        btn_in = '0;
        sw_in = '0;
        seed = 32'h16cb;
        error_count = 0;
        check_count = 0;
        for (combo = 0; combo < 4; combo++) begin
            hold[combo] = 0;
        end
        reset_model();

        // all digits read zero under reset in every switch setting
        @(posedge clk);
        #10;
        for (combo = 0; combo < 16; combo++) begin
            sw_in = 4'(combo);
            #4;
            check_value("reset_zero", 16'h0000, digits);
        end
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #10;
        sw_in = '0;
        reset = 1'b0;

        drive_cycle("stopwatch_count", BTN_RUN, 4'b0000);
        run_phase("stopwatch_count", COUNT_CYCLES, 4'b0000, 4'b1111, 4'b0000);
        run_phase("stopwatch_hold_clear", HOLD_CYCLES, BTN_RUN | BTN_CLEAR, 4'b1111, 4'b0000);
        run_phase("watch_free", FREE_CYCLES, BTN_RUN, 4'b1111, SW_WATCH);
        run_phase("count_down", DOWN_CYCLES, BTN_RUN | BTN_CLEAR, SW_DOWN, SW_DOWN);

        // minutes stepped past 59 carry into hours
        repeat (61) begin
            drive_cycle("minute_wrap", BTN_UP, SW_WATCH | SW_HM);
            drive_cycle("minute_wrap", 4'b0000, SW_WATCH | SW_HM);
        end
        repeat (3) drive_cycle("held_step", BTN_UP, SW_WATCH | SW_HM | SW_HOUR);
        drive_cycle("held_step", 4'b0000, SW_WATCH | SW_HM | SW_HOUR);

        run_phase("watch_set", SET_CYCLES, BTN_UP | BTN_DOWN, SW_DOWN | SW_WATCH | SW_HM,
                  SW_WATCH | SW_HM);
        run_phase("view_select", VIEW_CYCLES, 4'b1111, 4'b0000, 4'b0000);

        @(posedge clk);
        $display("run finished: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- hdl/clock_defs.svh
`ifndef CLOCK_DEFS_SVH
`define CLOCK_DEFS_SVH

// system clock and centisecond tick rates
`define CLK_HZ   100_000_000
`define TICK_HZ  100

// counter moduli, csec up to hour
`define CSEC_MOD 100
`define SEC_MOD  60
`define MIN_MOD  60
`define HOUR_MOD 24

// field widths
`define CSEC_W   7
`define SEC_W    6
`define MIN_W    6
`define HOUR_W   5

`endif

//--- hdl/clock_pkg.sv
`include "clock_defs.svh"

package clock_pkg;

    // raw button levels from the panel
    typedef struct packed {
        logic run_stop;
        logic clear;
        logic up;
        logic down;
    } panel_btn_t;

    // switch levels from the panel
    typedef struct packed {
        logic count_down;
        logic show_watch;
        logic show_hm;
        logic set_hour;
    } panel_sw_t;

    // control bundle, run is a level and clear/up/down are one-cycle pulses
    typedef struct packed {
        logic run;
        logic clear;
        logic up;
        logic down;
        logic count_down;
        logic set_hour;
    } panel_ctrl_t;

    typedef struct packed {
        logic [`HOUR_W-1:0] hour;
        logic [`MIN_W-1:0]  min;
        logic [`SEC_W-1:0]  sec;
        logic [`CSEC_W-1:0] csec;
    } time_t;

    // four BCD digits, leftmost first
    typedef struct packed {
        logic [3:0] left_tens;
        logic [3:0] left_ones;
        logic [3:0] right_tens;
        logic [3:0] right_ones;
    } bcd_digits_t;

endpackage

//--- hdl/display_format.sv
`timescale 1ns/1ps

module display_format (
    input  clock_pkg::panel_sw_t   i_sw,
    input  clock_pkg::time_t       i_stopwatch,
    input  clock_pkg::time_t       i_watch,
    output clock_pkg::bcd_digits_t o_digits
);

    import clock_pkg::*;

    // wide enough for the largest field, csec
    localparam int FIELD_W = 7;

    time_t              shown;
    logic [FIELD_W-1:0] left_val;
    logic [FIELD_W-1:0] right_val;
    logic [7:0]         left_bcd;
    logic [7:0]         right_bcd;

    // tens in the upper nibble, ones in the lower
    function automatic logic [7:0] bcd_split(input logic [FIELD_W-1:0] val);
        logic [FIELD_W-1:0] tens;
        logic [FIELD_W-1:0] ones;
        tens = val / FIELD_W'(10);
        ones = val % FIELD_W'(10);
        return {tens[3:0], ones[3:0]};
    endfunction

    // timekeeper select
    assign shown = i_sw.show_watch ? i_watch : i_stopwatch;

    // hh:mm or ss:cc
    always_comb begin
        if (i_sw.show_hm) begin
            left_val  = FIELD_W'(shown.hour);
            right_val = FIELD_W'(shown.min);
        end else begin
            left_val  = FIELD_W'(shown.sec);
            right_val = shown.csec;
        end
    end

    assign left_bcd  = bcd_split(left_val);
    assign right_bcd = bcd_split(right_val);

    assign o_digits = '{
        left_tens:  left_bcd[7:4],
        left_ones:  left_bcd[3:0],
        right_tens: right_bcd[7:4],
        right_ones: right_bcd[3:0]
    };

endmodule

//--- hdl/panel_control.sv
`timescale 1ns/1ps

module panel_control (
    input  logic                   clk,
    input  logic                   reset,
    input  clock_pkg::panel_btn_t  i_btn,
    input  clock_pkg::panel_sw_t   i_sw,
    output clock_pkg::panel_ctrl_t o_ctrl
);

    import clock_pkg::*;

    panel_btn_t btn_prev;
    panel_btn_t rise;
    logic       run;
    logic       clear_pls;
    logic       up_pls;
    logic       down_pls;

    // rising edge against last sampled level
    assign rise = i_btn & ~btn_prev;

    // ==================================================
    // edge pulses and run flip-flop
    // ==================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            btn_prev  <= '0;
            run       <= 1'b0;
            clear_pls <= 1'b0;
            up_pls    <= 1'b0;
            down_pls  <= 1'b0;
        end else begin
            btn_prev  <= i_btn;
            clear_pls <= rise.clear;
            up_pls    <= rise.up;
            down_pls  <= rise.down;
            // held button toggles only once
            if (rise.run_stop) begin
                run <= ~run;
            end
        end
    end

    assign o_ctrl = '{
        run:        run,
        clear:      clear_pls,
        up:         up_pls,
        down:       down_pls,
        count_down: i_sw.count_down,
        set_hour:   i_sw.set_hour
    };

endmodule

//--- hdl/stopwatch_core.sv
`timescale 1ns/1ps
`include "clock_defs.svh"

module stopwatch_core #(
    parameter int TICK_DIVIDE = `CLK_HZ / `TICK_HZ
) (
    input  logic                   clk,
    input  logic                   reset,
    input  clock_pkg::panel_ctrl_t i_ctrl,
    output clock_pkg::time_t       o_time
);

    import clock_pkg::*;

    logic                tick;
    logic                csec_step;
    logic                sec_carry;
    logic                min_carry;
    logic [`CSEC_W-1:0]  csec_cnt;
    logic [`SEC_W-1:0]   sec_cnt;
    logic [`MIN_W-1:0]   min_cnt;
    logic [`HOUR_W-1:0]  hour_cnt;
    logic                csec_carry;

    // tick source only runs with the stopwatch
    tick_gen #(.DIVIDE(TICK_DIVIDE)) tick_gen_inst (
        .clk      (clk),
        .reset    (reset),
        .i_enable (i_ctrl.run),
        .o_tick   (tick)
    );

    assign csec_step = tick & i_ctrl.run;

    // ==================================================
    // csec -> sec -> min -> hour chain
    // ==================================================
    time_counter #(.WIDTH(`CSEC_W), .MODULUS(`CSEC_MOD)) csec_inst (
        .clk(clk), .reset(reset), .i_clear(i_ctrl.clear), .i_step(csec_step),
        .i_down(i_ctrl.count_down), .o_count(csec_cnt), .o_carry(csec_carry)
    );

    time_counter #(.WIDTH(`SEC_W), .MODULUS(`SEC_MOD)) sec_inst (
        .clk(clk), .reset(reset), .i_clear(i_ctrl.clear), .i_step(csec_carry),
        .i_down(i_ctrl.count_down), .o_count(sec_cnt), .o_carry(sec_carry)
    );

    time_counter #(.WIDTH(`MIN_W), .MODULUS(`MIN_MOD)) min_inst (
        .clk(clk), .reset(reset), .i_clear(i_ctrl.clear), .i_step(sec_carry),
        .i_down(i_ctrl.count_down), .o_count(min_cnt), .o_carry(min_carry)
    );

    // hour carry is the end of the chain
    time_counter #(.WIDTH(`HOUR_W), .MODULUS(`HOUR_MOD)) hour_inst (
        .clk(clk), .reset(reset), .i_clear(i_ctrl.clear), .i_step(min_carry),
        .i_down(i_ctrl.count_down), .o_count(hour_cnt), .o_carry()
    );

    assign o_time = '{hour: hour_cnt, min: min_cnt, sec: sec_cnt, csec: csec_cnt};

endmodule

//--- hdl/stopwatch_watch.sv
`timescale 1ns/1ps
`include "clock_defs.svh"

module stopwatch_watch #(
    parameter int TICK_DIVIDE = `CLK_HZ / `TICK_HZ
) (
    input  logic                   clk,
    input  logic                   reset,
    input  clock_pkg::panel_btn_t  i_btn,
    input  clock_pkg::panel_sw_t   i_sw,
    output clock_pkg::bcd_digits_t o_digits
);

    import clock_pkg::*;

    panel_ctrl_t ctrl;
    time_t       stopwatch_time;
    time_t       watch_time;

    // ==================================================
    // input side
    // ==================================================
    panel_control panel_control_inst (
        .clk    (clk),
        .reset  (reset),
        .i_btn  (i_btn),
        .i_sw   (i_sw),
        .o_ctrl (ctrl)
    );

    // two timekeepers share the control bundle
    stopwatch_core #(.TICK_DIVIDE(TICK_DIVIDE)) stopwatch_core_inst (
        .clk    (clk),
        .reset  (reset),
        .i_ctrl (ctrl),
        .o_time (stopwatch_time)
    );

    watch_core #(.TICK_DIVIDE(TICK_DIVIDE)) watch_core_inst (
        .clk    (clk),
        .reset  (reset),
        .i_ctrl (ctrl),
        .o_time (watch_time)
    );

    // output side
    display_format display_format_inst (
        .i_sw        (i_sw),
        .i_stopwatch (stopwatch_time),
        .i_watch     (watch_time),
        .o_digits    (o_digits)
    );

endmodule

//--- hdl/tick_gen.sv
`timescale 1ns/1ps
`include "clock_defs.svh"

module tick_gen #(
    parameter int DIVIDE = `CLK_HZ / `TICK_HZ
) (
    input  logic clk,
    input  logic reset,
    input  logic i_enable,
    output logic o_tick
);

    localparam int CNT_W = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

    logic [CNT_W-1:0] count;
    logic             last;

    // terminal count of enabled cycles
    assign last = (count == CNT_W'(DIVIDE - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else begin
            o_tick <= i_enable & last;
            // count held while disabled
            if (i_enable) begin
                if (last) begin
                    count <= '0;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/time_counter.sv
`timescale 1ns/1ps

module time_counter #(
    parameter int WIDTH   = 7,
    parameter int MODULUS = 100
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             i_clear,
    input  logic             i_step,
    input  logic             i_down,
    output logic [WIDTH-1:0] o_count,
    output logic             o_carry
);

    logic [WIDTH-1:0] count;
    logic             at_top;
    logic             at_zero;
    logic             wrap;

    assign at_top  = (count == WIDTH'(MODULUS - 1));
    assign at_zero = (count == '0);
    assign wrap    = i_down ? at_zero : at_top;

    // carry in the same cycle as the wrapping step
    assign o_carry = i_step & ~i_clear & wrap;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (i_clear) begin
            count <= '0;
        end else if (i_step) begin
            if (i_down) begin
                // down, zero wraps to the top value
                count <= at_zero ? WIDTH'(MODULUS - 1) : count - 1'b1;
            end else begin
                count <= at_top ? '0 : count + 1'b1;
            end
        end
    end

    assign o_count = count;

endmodule

//--- hdl/watch_core.sv
`timescale 1ns/1ps
`include "clock_defs.svh"

module watch_core #(
    parameter int TICK_DIVIDE = `CLK_HZ / `TICK_HZ
) (
    input  logic                   clk,
    input  logic                   reset,
    input  clock_pkg::panel_ctrl_t i_ctrl,
    output clock_pkg::time_t       o_time
);

    import clock_pkg::*;

    logic                tick;
    logic                csec_carry;
    logic                sec_carry;
    logic                min_carry;
    logic                step_pls;
    logic                min_pls;
    logic                hour_pls;
    logic                min_step;
    logic                hour_step;
    logic                min_down;
    logic                hour_down;
    logic                pls_down;
    logic [`CSEC_W-1:0]  csec_cnt;
    logic [`SEC_W-1:0]   sec_cnt;
    logic [`MIN_W-1:0]   min_cnt;
    logic [`HOUR_W-1:0]  hour_cnt;

    // always running
    tick_gen #(.DIVIDE(TICK_DIVIDE)) tick_gen_inst (
        .clk      (clk),
        .reset    (reset),
        .i_enable (1'b1),
        .o_tick   (tick)
    );

    // ==================================================
    // set steering, up wins over down
    // ==================================================
    assign step_pls = i_ctrl.up | i_ctrl.down;
    assign pls_down = ~i_ctrl.up;
    assign min_pls  = step_pls & ~i_ctrl.set_hour;
    assign hour_pls = step_pls & i_ctrl.set_hour;

    // pulse takes the place of the carry below
    assign min_step  = min_pls | sec_carry;
    assign hour_step = hour_pls | min_carry;
    assign min_down  = min_pls ? pls_down : i_ctrl.count_down;
    assign hour_down = hour_pls ? pls_down : i_ctrl.count_down;

    time_counter #(.WIDTH(`CSEC_W), .MODULUS(`CSEC_MOD)) csec_inst (
        .clk(clk), .reset(reset), .i_clear(1'b0), .i_step(tick),
        .i_down(i_ctrl.count_down), .o_count(csec_cnt), .o_carry(csec_carry)
    );

    time_counter #(.WIDTH(`SEC_W), .MODULUS(`SEC_MOD)) sec_inst (
        .clk(clk), .reset(reset), .i_clear(1'b0), .i_step(csec_carry),
        .i_down(i_ctrl.count_down), .o_count(sec_cnt), .o_carry(sec_carry)
    );

    time_counter #(.WIDTH(`MIN_W), .MODULUS(`MIN_MOD)) min_inst (
        .clk(clk), .reset(reset), .i_clear(1'b0), .i_step(min_step),
        .i_down(min_down), .o_count(min_cnt), .o_carry(min_carry)
    );

    // top stage, carry out not needed
    time_counter #(.WIDTH(`HOUR_W), .MODULUS(`HOUR_MOD)) hour_inst (
        .clk(clk), .reset(reset), .i_clear(1'b0), .i_step(hour_step),
        .i_down(hour_down), .o_count(hour_cnt), .o_carry()
    );

    assign o_time = '{hour: hour_cnt, min: min_cnt, sec: sec_cnt, csec: csec_cnt};

endmodule

//--- stopwatch_watch.f
+incdir+hdl
hdl/clock_pkg.sv
hdl/tick_gen.sv
hdl/time_counter.sv
hdl/panel_control.sv
hdl/stopwatch_core.sv
hdl/watch_core.sv
hdl/display_format.sv
hdl/stopwatch_watch.sv
dv/tb_stopwatch_watch.sv
